// File: design/ahb_cache_pkg.sv
package ahb_cache_pkg;

    // ========================================
    // Geometry
    // ========================================
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTE_OFF_W     = 2;      // Word transfers only.
    localparam int CACHE_BYTES    = 8192;
    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = LINE_BITS / DATA_W;
    localparam int NUM_LINES      = CACHE_BYTES * 8 / LINE_BITS;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W        = $clog2(NUM_LINES);
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    word_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // ========================================
    // AHB-Lite fields and buses
    // ========================================
    typedef logic [1:0] htrans_t;
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    typedef logic [2:0] hburst_t;
    localparam hburst_t HBURST_SINGLE = 3'b000;
    localparam hburst_t HBURST_INCR4  = 3'b011;

    typedef struct packed {
        addr_t   haddr;
        htrans_t htrans;
        logic    hwrite;
    } up_req_t;

    typedef struct packed {
        word_t hrdata;
        logic  hready;
    } up_rsp_t;

    typedef struct packed {
        addr_t   haddr;
        htrans_t htrans;
        logic    hwrite;
        hburst_t hburst;
        word_t   hwdata;
    } dn_req_t;

    typedef struct packed {
        word_t hrdata;
        logic  hready;
    } dn_rsp_t;

    // Job handed from the front end to the refill engine.
    typedef struct packed {
        addr_t addr;
        logic  is_write;
        word_t wdata;
    } refill_req_t;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_LOOKUP,
        HS_WAIT_REFILL,
        HS_WAIT_WRITE
    } handler_state_e;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_ADDR,
        RS_BEATS,
        RS_DONE
    } refill_state_e;

endpackage

// File: design/transfer_handler.sv
`timescale 1ns/10ps

module transfer_handler import ahb_cache_pkg::*; (
    input  logic        upstream_intf,
    input  logic        arst_n,
    input  up_req_t     up_req,
    input  word_t       up_hwdata,
    output up_rsp_t     up_rsp,
    output addr_t       lookup_addr,
    input  logic        hit,
    input  word_t       rd_word,
    output logic        wr_en,
    output word_t       wr_word,
    output logic        refill_valid,
    input  logic        refill_ready,
    output refill_req_t refill_job,
    input  logic        refill_done
);

    handler_state_e state_q;
    handler_state_e state_d;
    addr_t          addr_q;
    logic           write_q;
    word_t          wdata_q;
    logic           xfer_req;
    logic           accept;

    // Upstream bursts arrive as plain transfers, so SEQ is taken like NONSEQ.
    assign xfer_req = (up_req.htrans == HTRANS_NONSEQ) || (up_req.htrans == HTRANS_SEQ);
    assign accept   = up_rsp.hready && xfer_req;

    assign lookup_addr = addr_q;
    assign wr_word     = wdata_q;

    // Write data is sampled in the data phase, held stable while HREADY is low.
    assign refill_job.addr     = addr_q;
    assign refill_job.is_write = write_q;
    assign refill_job.wdata    = up_hwdata;

    // ========================================
    // Upstream response
    // ========================================
    always_comb begin
        up_rsp.hrdata = rd_word;
        case (state_q)
            HS_LOOKUP:      up_rsp.hready = !write_q && hit;   // Zero-wait read hit.
            HS_WAIT_REFILL: up_rsp.hready = 1'b0;
            HS_WAIT_WRITE:  up_rsp.hready = refill_done;
            default:        up_rsp.hready = 1'b1;
        endcase
    end

    // ========================================
    // Control FSM
    // ========================================
    always_comb begin
        state_d      = state_q;
        refill_valid = 1'b0;
        wr_en        = 1'b0;
        case (state_q)
            HS_IDLE: begin
                if (accept) begin
                    state_d = HS_LOOKUP;
                end
            end
            HS_LOOKUP: begin
                if (write_q || !hit) begin
                    refill_valid = 1'b1;
                    if (refill_ready) begin
                        state_d = write_q ? HS_WAIT_WRITE : HS_WAIT_REFILL;
                    end
                end else if (!accept) begin
                    state_d = HS_IDLE;   // Hit served, no new transfer behind it.
                end
            end
            HS_WAIT_REFILL: begin
                // Re-lookup the freshly filled line.
                if (refill_done) begin
                    state_d = HS_LOOKUP;
                end
            end
            HS_WAIT_WRITE: begin
                if (refill_done) begin
                    wr_en   = hit;   // Keep a resident copy coherent.
                    state_d = accept ? HS_LOOKUP : HS_IDLE;
                end
            end
            default: state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= HS_IDLE;
            addr_q  <= '0;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                addr_q  <= up_req.haddr;
                write_q <= up_req.hwrite;
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (refill_valid && refill_ready && write_q) begin
            wdata_q <= up_hwdata;
        end
    end

endmodule

// File: design/cache_array.sv
`timescale 1ns/10ps

module cache_array import ahb_cache_pkg::*; (
    input  logic   upstream_intf,
    input  logic   arst_n,
    input  addr_t  lookup_addr,
    output logic   hit,
    output word_t  rd_word,
    input  logic   wr_en,
    input  word_t  wr_word,
    input  logic   fill_en,
    input  index_t fill_index,
    input  tag_t   fill_tag,
    input  line_t  fill_line
);

    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_mem  [NUM_LINES];
    line_t                data_mem [NUM_LINES];

    tag_t    lu_tag;
    index_t  lu_index;
    offset_t lu_offset;
    line_t   lu_line;
    tag_t    lu_stored_tag;

    // ========================================
    // Address parsing
    // ========================================
    // Layout is tag | index | word offset | byte offset.
    assign lu_offset = lookup_addr[BYTE_OFF_W +: OFFSET_W];
    assign lu_index  = lookup_addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    assign lu_tag    = lookup_addr[ADDR_W-1 -: TAG_W];

    // ========================================
    // Lookup
    // ========================================
    assign lu_line       = data_mem[lu_index];
    assign lu_stored_tag = tag_mem[lu_index];

    assign hit = valid_q[lu_index] && (lu_stored_tag == lu_tag);

    // Word select within the line.
    always_comb begin
        rd_word = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (lu_offset == offset_t'(w)) begin
                rd_word = lu_line[w*DATA_W +: DATA_W];
            end
        end
    end

    // ========================================
    // Update
    // ========================================
    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;   // Invalidate every line.
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_line;
        end else if (wr_en) begin
            data_mem[lu_index][lu_offset*DATA_W +: DATA_W] <= wr_word;
        end
    end

endmodule

// File: design/line_refill.sv
`timescale 1ns/10ps

module line_refill import ahb_cache_pkg::*; (
    input  logic        upstream_intf,
    input  logic        arst_n,
    input  logic        refill_valid,
    output logic        refill_ready,
    input  refill_req_t refill_job,
    output logic        refill_done,
    output dn_req_t     dn_req,
    input  dn_rsp_t     dn_rsp,
    output logic        fill_en,
    output index_t      fill_index,
    output tag_t        fill_tag,
    output line_t       fill_line
);

    refill_state_e     state_q;
    refill_state_e     state_d;
    refill_req_t       job_q;
    logic [OFFSET_W:0] addr_cnt_q;   // Next beat to put on the bus.
    offset_t           data_cnt_q;   // Beat in its data phase.
    line_t             line_q;
    logic              issuing;
    logic              last_beat;

    assign fill_index = job_q.addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    assign fill_tag   = job_q.addr[ADDR_W-1 -: TAG_W];

    assign issuing   = (state_q == RS_BEATS) && !job_q.is_write &&
                       (addr_cnt_q < WORDS_PER_LINE);
    assign last_beat = job_q.is_write || (data_cnt_q == offset_t'(WORDS_PER_LINE - 1));

    // Last word comes straight off the bus so the line is written with that beat.
    always_comb begin
        fill_line = line_q;
        fill_line[data_cnt_q*DATA_W +: DATA_W] = dn_rsp.hrdata;
    end

    // ========================================
    // Bus FSM
    // ========================================
    always_comb begin
        state_d       = state_q;
        refill_ready  = 1'b0;
        refill_done   = 1'b0;
        fill_en       = 1'b0;
        dn_req.haddr  = {fill_tag, fill_index, offset_t'(addr_cnt_q), {BYTE_OFF_W{1'b0}}};
        dn_req.htrans = HTRANS_IDLE;
        dn_req.hwrite = 1'b0;
        dn_req.hburst = HBURST_SINGLE;
        dn_req.hwdata = job_q.wdata;
        case (state_q)
            RS_IDLE: begin
                refill_ready = 1'b1;
                if (refill_valid) begin
                    state_d = RS_ADDR;
                end
            end
            RS_ADDR: begin
                dn_req.htrans = HTRANS_NONSEQ;
                dn_req.hwrite = job_q.is_write;
                if (job_q.is_write) begin
                    dn_req.haddr = job_q.addr;
                end else begin
                    dn_req.hburst = HBURST_INCR4;   // Always from word 0.
                end
                if (dn_rsp.hready) begin
                    state_d = RS_BEATS;
                end
            end
            RS_BEATS: begin
                // Next address overlaps the current data phase.
                if (issuing) begin
                    dn_req.htrans = HTRANS_SEQ;
                    dn_req.hburst = HBURST_INCR4;
                end
                if (dn_rsp.hready && last_beat) begin
                    fill_en = !job_q.is_write;
                    state_d = RS_DONE;
                end
            end
            RS_DONE: begin
                refill_done = 1'b1;
                state_d     = RS_IDLE;
            end
            default: state_d = RS_IDLE;
        endcase
    end

    always_ff @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= RS_IDLE;
            addr_cnt_q <= '0;
            data_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RS_IDLE) begin
                addr_cnt_q <= '0;
                data_cnt_q <= '0;
            end else if (dn_rsp.hready) begin
                if (state_q == RS_ADDR) begin
                    addr_cnt_q <= 1'b1;
                end else if (state_q == RS_BEATS) begin
                    data_cnt_q <= data_cnt_q + 1'b1;
                    if (issuing) begin
                        addr_cnt_q <= addr_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    // Job and collected beats.
    always_ff @(posedge upstream_intf) begin
        if (refill_valid && refill_ready) begin
            job_q <= refill_job;
        end
        if ((state_q == RS_BEATS) && dn_rsp.hready) begin
            line_q[data_cnt_q*DATA_W +: DATA_W] <= dn_rsp.hrdata;
        end
    end

endmodule

// File: design/ahb_read_cache.sv
`timescale 1ns/10ps

module ahb_read_cache import ahb_cache_pkg::*; (
    input  logic    upstream_intf,
    input  logic    arst_n,
    input  up_req_t up_req,
    input  word_t   up_hwdata,
    output up_rsp_t up_rsp,
    output dn_req_t dn_req,
    input  dn_rsp_t dn_rsp
);

    // ========================================
    // Internal wiring
    // ========================================
    addr_t       lookup_addr;
    logic        hit;
    word_t       rd_word;
    logic        wr_en;
    word_t       wr_word;

    logic        refill_valid;
    logic        refill_ready;
    refill_req_t refill_job;
    logic        refill_done;

    logic        fill_en;
    index_t      fill_index;
    tag_t        fill_tag;
    line_t       fill_line;

    // Upstream AHB-Lite slave.
    transfer_handler transfer_handler_i (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .up_req        (up_req),
        .up_hwdata     (up_hwdata),
        .up_rsp        (up_rsp),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .rd_word       (rd_word),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .refill_valid  (refill_valid),
        .refill_ready  (refill_ready),
        .refill_job    (refill_job),
        .refill_done   (refill_done)
    );

    cache_array cache_array_i (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .rd_word       (rd_word),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line)
    );

    // Downstream AHB-Lite master.
    line_refill line_refill_i (
        .upstream_intf (upstream_intf),
        .arst_n        (arst_n),
        .refill_valid  (refill_valid),
        .refill_ready  (refill_ready),
        .refill_job    (refill_job),
        .refill_done   (refill_done),
        .dn_req        (dn_req),
        .dn_rsp        (dn_rsp),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line)
    );

endmodule

// File: tb/ahb_mem_model.sv
`timescale 1ns/10ps

module ahb_mem_model import ahb_cache_pkg::*; (
    input  logic    upstream_intf,
    input  logic    arst_n,
    input  dn_req_t dn_req,
    output dn_rsp_t dn_rsp
);

    word_t mem [addr_t];   // Only words written over the bus.

    // Data phase in progress.
    logic  dp_valid  = 1'b0;
    logic  dp_write  = 1'b0;
    addr_t dp_addr   = '0;
    int    wait_left = 0;

    logic  hready_q  = 1'b1;
    word_t hrdata_q  = '0;

    assign dn_rsp = '{hrdata: hrdata_q, hready: hready_q};

    // Power-up contents, spread over the whole address.
    function automatic word_t init_word(input addr_t addr);
        word_t h;
        h = addr * 32'h9e37_79b1;
        h = h ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
        return h;
    endfunction

    function automatic word_t read_word(input addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return init_word(addr);
    endfunction

    // ========================================
    // Pipelined AHB-Lite slave
    // ========================================
    always @(posedge upstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            dp_valid  = 1'b0;
            wait_left = 0;
            hready_q <= 1'b1;
            hrdata_q <= '0;
        end else begin
            if (dn_rsp.hready) begin
                if (dp_valid && dp_write) begin
                    mem[dp_addr] = dn_req.hwdata;   // Write data phase completes.
                end
                dp_valid  = dn_req.htrans[1];      // NONSEQ or SEQ.
                dp_write  = dn_req.hwrite;
                dp_addr   = dn_req.haddr;
                wait_left = $urandom % 4;
            end else if (wait_left > 0) begin
                wait_left--;
            end
            hready_q <= !dp_valid || (wait_left == 0);
            hrdata_q <= (dp_valid && !dp_write && (wait_left == 0)) ? read_word(dp_addr) : '0;
        end
    end

endmodule

// File: tb/ahb_read_cache_tb.sv
`timescale 1ns/10ps

module ahb_read_cache_tb import ahb_cache_pkg::*; ();

    localparam int SEED         = 65264;
    localparam int CLK_PERIOD   = 40;
    localparam int RANDOM_XFERS = 200;   // Per random phase.
    localparam int TOTAL_XFERS  = 2 * RANDOM_XFERS + 16;
    // Worst refill is 5 beats of 4 cycles each, doubled as margin.
    localparam int WATCHDOG_NS  = TOTAL_XFERS * 5 * 4 * CLK_PERIOD * 2;

    logic    upstream_intf;
    logic    arst_n;
    up_req_t up_req;
    word_t   up_hwdata;
    up_rsp_t up_rsp;
    dn_req_t dn_req;
    dn_rsp_t dn_rsp;

    // Reference cache and memory.
    logic    ref_valid [NUM_LINES];
    tag_t    ref_tag   [NUM_LINES];
    word_t   written   [addr_t];

    dn_req_t dn_log [$];   // Accepted downstream address phases.
    word_t   wr_log [$];   // Downstream write data.
    logic    wr_pending = 1'b0;

    tag_t    tag_pool   [3] = '{19'h00001, 19'h00a5c, 19'h3f00f};
    index_t  index_pool [4] = '{9'h000, 9'h07f, 9'h100, 9'h1ff};

    ahb_read_cache ahb_read_cache_i (.*);
    ahb_mem_model  mem_model_i (.*);

    initial upstream_intf = 1'b0;
    always #(CLK_PERIOD / 2) upstream_intf = ~upstream_intf;

    // ========================================
    // Downstream monitor
    // ========================================
    always @(posedge upstream_intf) begin
        if (arst_n && dn_rsp.hready) begin
            if (wr_pending) begin
                wr_log.push_back(dn_req.hwdata);
            end
            wr_pending = dn_req.htrans[1] && dn_req.hwrite;
            if (dn_req.htrans[1]) begin
                dn_log.push_back(dn_req);
            end
        end
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic word_t expected_word(input addr_t addr);
        return written.exists(addr) ? written[addr] : mem_model_i.init_word(addr);
    endfunction

    task automatic clear_reference();
        for (int i = 0; i < NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // One upstream transfer, started and ended on a rising edge.
    task automatic run_transfer(input addr_t addr, input logic write, input word_t wdata,
                                output int dn_count);
        index_t idx;
        tag_t   tg;
        logic   exp_hit;
        addr_t  line_base;
        int     log_start;
        int     wr_start;
        int     waits;
        word_t  got;
        idx       = addr[BYTE_OFF_W + OFFSET_W +: INDEX_W];
        tg        = addr[ADDR_W-1 -: TAG_W];
        exp_hit   = ref_valid[idx] && (ref_tag[idx] == tg);
        line_base = addr & ~addr_t'(WORDS_PER_LINE * 4 - 1);
        up_req <= '{haddr: addr, htrans: HTRANS_NONSEQ, hwrite: write};
        @(negedge upstream_intf);
        log_start = dn_log.size();
        wr_start  = wr_log.size();
        while (!up_rsp.hready) begin
            @(negedge upstream_intf);
        end
        @(posedge upstream_intf);
        up_req    <= '{haddr: addr, htrans: HTRANS_IDLE, hwrite: 1'b0};
        up_hwdata <= wdata;
        waits = 0;
        @(negedge upstream_intf);
        while (!up_rsp.hready) begin
            waits++;
            @(negedge upstream_intf);
        end
        got      = up_rsp.hrdata;
        dn_count = dn_log.size() - log_start;
        @(posedge upstream_intf);

        if (write) begin
            check_value("downstream transfers", dn_count, 1);
            check_value("dn_req.htrans", dn_log[log_start].htrans, HTRANS_NONSEQ);
            check_value("dn_req.hburst", dn_log[log_start].hburst, HBURST_SINGLE);
            check_value("dn_req.hwrite", dn_log[log_start].hwrite, 1'b1);
            check_value("dn_req.haddr", dn_log[log_start].haddr, addr);
            check_value("downstream write beats", wr_log.size() - wr_start, 1);
            check_value("dn_req.hwdata", wr_log[wr_start], wdata);
            written[addr] = wdata;   // No allocate on a miss.
        end else if (exp_hit) begin
            check_value("read hit wait cycles", waits, 0);
            check_value("downstream transfers", dn_count, 0);
        end else begin
            check_value("read miss stalled", waits > 0, 1'b1);
            check_value("downstream transfers", dn_count, WORDS_PER_LINE);
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                check_value("dn_req.htrans", dn_log[log_start + b].htrans,
                            (b == 0) ? HTRANS_NONSEQ : HTRANS_SEQ);
                check_value("dn_req.hburst", dn_log[log_start + b].hburst, HBURST_INCR4);
                check_value("dn_req.hwrite", dn_log[log_start + b].hwrite, 1'b0);
                check_value("dn_req.haddr", dn_log[log_start + b].haddr, line_base + 4 * b);
            end
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tg;
        end
        if (!write) begin
            check_value("up_rsp.hrdata", got, expected_word(addr));
        end
    endtask

    task automatic random_phase();
        addr_t addr;
        int    dn_count;
        for (int n = 0; n < RANDOM_XFERS; n++) begin
            addr = {tag_pool[$urandom % 3], index_pool[$urandom % 4],
                    offset_t'($urandom % 4), 2'b00};
            run_transfer(addr, ($urandom % 10) < 3, $urandom, dn_count);   // ~30% writes.
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        addr_t addr;
        int    dn_count;
        void'($urandom(SEED));
        arst_n    = 1'b0;
        up_req    = '{haddr: '0, htrans: HTRANS_IDLE, hwrite: 1'b0};
        up_hwdata = '0;
        clear_reference();
        repeat (4) @(posedge upstream_intf);
        arst_n <= 1'b1;

        random_phase();

        // Same index, different tags, so every read evicts the other line.
        for (int n = 0; n < 6; n++) begin
            addr = {tag_pool[n % 2], index_t'(9'h055), offset_t'(n % 4), 2'b00};
            run_transfer(addr, 1'b0, '0, dn_count);
            check_value("conflict refill beats", dn_count, WORDS_PER_LINE);
        end

        addr = {tag_pool[2], index_t'(9'h0aa), offset_t'(3), 2'b00};
        run_transfer(addr, 1'b0, '0, dn_count);
        run_transfer(addr, 1'b0, '0, dn_count);
        check_value("resident read beats", dn_count, 0);
        arst_n <= 1'b0;   // Reset again mid-run.
        repeat (4) @(posedge upstream_intf);
        arst_n <= 1'b1;
        clear_reference();
        run_transfer(addr, 1'b0, '0, dn_count);
        check_value("refill beats after reset", dn_count, WORDS_PER_LINE);

        random_phase();

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: transfers did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $fatal(1, "Simulation timed out");
    end

endmodule

// File: ahb_read_cache.f
design/ahb_cache_pkg.sv
design/transfer_handler.sv
design/cache_array.sv
design/line_refill.sv
design/ahb_read_cache.sv
tb/ahb_mem_model.sv
tb/ahb_read_cache_tb.sv

// File: Bender.yml
package:
  name: ahb_read_cache

sources:
  # Package first, then the blocks, then the top level.
  - design/ahb_cache_pkg.sv
  - design/transfer_handler.sv
  - design/cache_array.sv
  - design/line_refill.sv
  - design/ahb_read_cache.sv

  - target: simulation
    files:
      - tb/ahb_mem_model.sv
      - tb/ahb_read_cache_tb.sv
